// ==== rtl/src_stream_pkg.sv ====
// source streamer shared widths, register map, bus structs and controller states
`default_nettype none

package src_stream_pkg;

  localparam int unsigned ADDR_W = 32;          // byte address
  localparam int unsigned DATA_W = 32;          // output stream beat
  localparam int unsigned MEM_W  = DATA_W + 32; // one spare word covers any byte offset
  localparam int unsigned CNT_W  = 16;          // lengths and element counters

  // apb register offsets
  localparam logic [7:0] REG_CTRL      = 8'h00; // bit 0 start
  localparam logic [7:0] REG_STATUS    = 8'h04; // bit 0 busy, bit 1 sticky done
  localparam logic [7:0] REG_BASE      = 8'h08;
  localparam logic [7:0] REG_D0_LEN    = 8'h0C;
  localparam logic [7:0] REG_D0_STRIDE = 8'h10;
  localparam logic [7:0] REG_D1_LEN    = 8'h14;
  localparam logic [7:0] REG_D1_STRIDE = 8'h18;

  // two-dimensional pattern
  typedef struct packed {
    logic [ADDR_W-1:0] base;
    logic [CNT_W-1:0]  d0_len;    // inner element count
    logic [ADDR_W-1:0] d0_stride; // inner step in bytes
    logic [CNT_W-1:0]  d1_len;    // outer row count
    logic [ADDR_W-1:0] d1_stride; // outer step in bytes
  } src_cfg_t;

  typedef struct packed {
    logic              req;
    logic [ADDR_W-1:0] addr; // word aligned
  } mem_req_t;

  typedef struct packed {
    logic             r_valid; // cannot be stalled
    logic [MEM_W-1:0] r_data;
  } mem_rsp_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    WORKING, // addresses still being issued
    DRAIN    // last address granted, waiting for beats
  } src_state_e;

endpackage

`default_nettype wire

// ==== rtl/src_fifo.sv ====
// synchronous circular-buffer fifo for any payload type
`timescale 1ns/1ps
`default_nettype none

module src_fifo #(
  parameter type         T     = logic [7:0],
  parameter int unsigned DEPTH = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  T     data_i,
  output logic full_o,
  input  logic pop_i,
  output T     data_o,
  output logic empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  T             mem_q [DEPTH]; // storage, no reset
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign empty_o = (cnt_q == '0);
  assign do_push = push_i & ~full_o;  // overflow dropped
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1); // wrap
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + CNT_W'(1);
        2'b01:   cnt_q <= cnt_q - CNT_W'(1);
        default: cnt_q <= cnt_q; // both or neither
      endcase
    end
  end

  assign data_o = mem_q[rd_ptr_q]; // head visible cycle after push

endmodule

`default_nettype wire

// ==== rtl/src_apb_regs.sv ====
// apb slave with the pattern registers, start pulse and busy/done status
`timescale 1ns/1ps
`default_nettype none

module src_apb_regs import src_stream_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  input  logic     busy_i,
  input  logic     done_i,
  output src_cfg_t cfg_o,
  output logic     start_o
);

  src_cfg_t    cfg_q;
  logic        start_q;
  logic        done_flag_q; // sticky until next start
  logic        access;
  logic        wr;
  logic        err;
  logic        do_start;
  logic [31:0] rdata;

  assign access = apb_req_i.psel & apb_req_i.penable; // access phase
  assign wr     = access & apb_req_i.pwrite;

  // read mux and error decode
  always_comb begin
    rdata = '0;
    err   = 1'b0;
    case (apb_req_i.paddr)
      REG_CTRL:      err = wr & apb_req_i.pwdata[0] & busy_i; // no restart while busy
      REG_STATUS: begin
        rdata = {30'b0, done_flag_q, busy_i};
        err   = wr; // read only
      end
      REG_BASE:      rdata = cfg_q.base;
      REG_D0_LEN:    rdata = 32'(cfg_q.d0_len);
      REG_D0_STRIDE: rdata = cfg_q.d0_stride;
      REG_D1_LEN:    rdata = 32'(cfg_q.d1_len);
      REG_D1_STRIDE: rdata = cfg_q.d1_stride;
      default:       err = access; // unmapped
    endcase
  end

  assign do_start = wr & ~err & (apb_req_i.paddr == REG_CTRL) & apb_req_i.pwdata[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q       <= '0;
      start_q     <= 1'b0;
      done_flag_q <= 1'b0;
    end else begin
      start_q <= do_start; // one cycle after access
      if (do_start)    done_flag_q <= 1'b0;
      else if (done_i) done_flag_q <= 1'b1;
      if (wr && !err) begin
        case (apb_req_i.paddr)
          REG_BASE:      cfg_q.base      <= apb_req_i.pwdata[ADDR_W-1:0];
          REG_D0_LEN:    cfg_q.d0_len    <= apb_req_i.pwdata[CNT_W-1:0];
          REG_D0_STRIDE: cfg_q.d0_stride <= apb_req_i.pwdata[ADDR_W-1:0];
          REG_D1_LEN:    cfg_q.d1_len    <= apb_req_i.pwdata[CNT_W-1:0];
          REG_D1_STRIDE: cfg_q.d1_stride <= apb_req_i.pwdata[ADDR_W-1:0];
          default: ; // ctrl handled by start
        endcase
      end
    end
  end

  assign apb_rsp_o.prdata  = rdata;
  assign apb_rsp_o.pready  = 1'b1;       // no wait states
  assign apb_rsp_o.pslverr = err & access;
  assign cfg_o             = cfg_q;
  assign start_o           = start_q;

endmodule

`default_nettype wire

// ==== rtl/src_addr_gen.sv ====
// two-dimensional byte address walker, one address per handshake, last flagged
`timescale 1ns/1ps
`default_nettype none

module src_addr_gen import src_stream_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              start_i,
  input  src_cfg_t          cfg_i,
  output logic              addr_valid_o,
  input  logic              addr_ready_i,
  output logic [ADDR_W-1:0] addr_o,
  output logic              last_o
);

  logic              active_q;
  logic [CNT_W-1:0]  i_q;         // inner index
  logic [CNT_W-1:0]  j_q;         // outer index
  logic [ADDR_W-1:0] addr_q;      // current address
  logic [ADDR_W-1:0] row_q;       // start of current row
  logic [CNT_W-1:0]  d0_len_q;
  logic [ADDR_W-1:0] d0_stride_q;
  logic [CNT_W-1:0]  d1_len_q;
  logic [ADDR_W-1:0] d1_stride_q;
  logic              i_last;
  logic              hs;

  assign i_last = (i_q == d0_len_q - CNT_W'(1));
  assign last_o = i_last & (j_q == d1_len_q - CNT_W'(1));
  assign hs     = active_q & addr_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q    <= 1'b0;
      i_q         <= '0;
      j_q         <= '0;
      addr_q      <= '0;
      row_q       <= '0;
      d0_len_q    <= '0;
      d0_stride_q <= '0;
      d1_len_q    <= '0;
      d1_stride_q <= '0;
    end else if (start_i) begin
      // latch pattern, restart walk
      active_q    <= 1'b1;
      i_q         <= '0;
      j_q         <= '0;
      addr_q      <= cfg_i.base;
      row_q       <= cfg_i.base;
      d0_len_q    <= cfg_i.d0_len;
      d0_stride_q <= cfg_i.d0_stride;
      d1_len_q    <= cfg_i.d1_len;
      d1_stride_q <= cfg_i.d1_stride;
    end else if (hs) begin
      if (last_o) begin
        active_q <= 1'b0; // pattern exhausted
      end else if (i_last) begin
        i_q    <= '0;              // next row
        j_q    <= j_q + CNT_W'(1);
        row_q  <= row_q + d1_stride_q;
        addr_q <= row_q + d1_stride_q;
      end else begin
        i_q    <= i_q + CNT_W'(1);
        addr_q <= addr_q + d0_stride_q;
      end
    end
  end

  assign addr_valid_o = active_q;
  assign addr_o       = addr_q; // held while not ready

endmodule

`default_nettype wire

// ==== rtl/src_realign.sv ====
// output register stage, picks the 32-bit beat at the byte offset of each response
`timescale 1ns/1ps
`default_nettype none

module src_realign import src_stream_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              rsp_valid_i,   // response head valid, offset always ahead
  input  logic [MEM_W-1:0]  rsp_data_i,
  input  logic [1:0]        offs_i,
  output logic              pop_o,         // pops response and offset together
  output logic              stream_valid_o,
  output logic [DATA_W-1:0] stream_data_o,
  input  logic              stream_ready_i
);

  logic              valid_q;
  logic [DATA_W-1:0] data_q;     // payload, no reset
  logic [DATA_W-1:0] beat;
  logic              load;

  // bytes offs..offs+3, little endian
  assign beat = rsp_data_i[{offs_i, 3'b000} +: DATA_W];

  // load when empty or draining this cycle
  assign load  = rsp_valid_i & (~valid_q | stream_ready_i);
  assign pop_o = load;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (stream_ready_i) begin
      valid_q <= 1'b0; // beat taken, nothing behind it
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) data_q <= beat; // held under stall
  end

  assign stream_valid_o = valid_q;
  assign stream_data_o  = data_q;

endmodule

`default_nettype wire

// ==== rtl/src_ctrl.sv ====
// streamer fsm, memory request issue and outstanding-request tracking
`timescale 1ns/1ps
`default_nettype none

module src_ctrl import src_stream_pkg::*; #(
  parameter int unsigned OUT_DEPTH = 8
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              start_i,
  output logic              busy_o,
  output logic              done_o,
  input  logic [ADDR_W-1:0] addr_i,       // address fifo head
  input  logic              last_seen_i,  // head is last of pattern
  input  logic              addr_empty_i,
  output logic              addr_pop_o,
  output mem_req_t          mem_req_o,
  input  logic              mem_gnt_i,
  output logic              offs_push_o,
  input  logic              beat_hs_i
);

  localparam int unsigned OUT_W = $clog2(OUT_DEPTH + 1);

  src_state_e       state_q;
  src_state_e       state_d;
  logic [OUT_W-1:0] out_cnt_q; // granted but not yet streamed
  logic             done_q;
  logic             finish;
  logic             req;
  logic             gnt_hs;

  assign busy_o = (state_q != IDLE);

  // cap in flight so offset and response fifos never overflow
  assign req    = busy_o & ~addr_empty_i & (out_cnt_q < OUT_W'(OUT_DEPTH));
  assign gnt_hs = req & mem_gnt_i;

  assign mem_req_o.req  = req;
  assign mem_req_o.addr = {addr_i[ADDR_W-1:2], 2'b00}; // word aligned fetch
  assign addr_pop_o     = gnt_hs;
  assign offs_push_o    = gnt_hs; // byte offset follows each grant

  always_comb begin
    state_d = state_q;
    finish  = 1'b0;
    case (state_q)
      IDLE:    if (start_i) state_d = WORKING;
      WORKING: if (gnt_hs && last_seen_i) state_d = DRAIN;
      DRAIN: begin
        if (out_cnt_q == '0 && addr_empty_i) begin
          state_d = IDLE; // all beats out
          finish  = 1'b1;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      out_cnt_q <= '0;
      done_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= finish; // pulse in first idle cycle
      case ({gnt_hs, beat_hs_i})
        2'b10:   out_cnt_q <= out_cnt_q + OUT_W'(1);
        2'b01:   out_cnt_q <= out_cnt_q - OUT_W'(1);
        default: out_cnt_q <= out_cnt_q;
      endcase
    end
  end

  assign done_o = done_q;

endmodule

`default_nettype wire

// ==== rtl/src_stream_top.sv ====
// memory-to-stream source streamer top, apb config, controller and datapath
`timescale 1ns/1ps
`default_nettype none

module src_stream_top import src_stream_pkg::*; #(
  parameter int unsigned OUT_DEPTH  = 8, // offset/response fifo depth, in-flight cap
  parameter int unsigned ADDR_DEPTH = 2
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  apb_req_t          apb_req_i,
  output apb_rsp_t          apb_rsp_o,
  output mem_req_t          mem_req_o,
  input  logic              mem_gnt_i,
  input  mem_rsp_t          mem_rsp_i,
  output logic              stream_valid_o,
  output logic [DATA_W-1:0] stream_data_o,
  input  logic              stream_ready_i,
  output logic              busy_o,
  output logic              done_o
);

  // address fifo entry
  typedef struct packed {
    logic              last;
    logic [ADDR_W-1:0] addr;
  } addr_entry_t;

  src_cfg_t         cfg;
  logic             start;
  logic             ag_valid;
  logic             ag_last;
  logic [ADDR_W-1:0] ag_addr;
  addr_entry_t      ag_entry;
  addr_entry_t      head;
  logic             addr_full;
  logic             addr_empty;
  logic             addr_pop;
  logic             offs_push;
  logic [1:0]       offs_head;
  logic [MEM_W-1:0] rsp_head;
  logic             rsp_empty;
  logic             rsp_valid;
  logic             rsp_pop;
  logic             beat_hs;

  assign ag_entry  = '{last: ag_last, addr: ag_addr};
  assign rsp_valid = ~rsp_empty;
  assign beat_hs   = stream_valid_o & stream_ready_i;

  src_apb_regs u_regs (
    .clk_i, .rst_ni, .apb_req_i, .apb_rsp_o,
    .busy_i (busy_o), .done_i (done_o), .cfg_o (cfg), .start_o (start)
  );

  src_addr_gen u_addr_gen (
    .clk_i, .rst_ni, .start_i (start), .cfg_i (cfg),
    .addr_valid_o (ag_valid), .addr_ready_i (~addr_full),
    .addr_o (ag_addr), .last_o (ag_last)
  );

  src_fifo #(.T (addr_entry_t), .DEPTH (ADDR_DEPTH)) u_addr_fifo (
    .clk_i, .rst_ni, .push_i (ag_valid), .data_i (ag_entry), .full_o (addr_full),
    .pop_i (addr_pop), .data_o (head), .empty_o (addr_empty)
  );

  src_ctrl #(.OUT_DEPTH (OUT_DEPTH)) u_ctrl (
    .clk_i, .rst_ni, .start_i (start), .busy_o, .done_o,
    .addr_i (head.addr), .last_seen_i (head.last), .addr_empty_i (addr_empty),
    .addr_pop_o (addr_pop), .mem_req_o, .mem_gnt_i,
    .offs_push_o (offs_push), .beat_hs_i (beat_hs)
  );

  // byte offsets of granted requests, in order
  src_fifo #(.T (logic [1:0]), .DEPTH (OUT_DEPTH)) u_offs_fifo (
    .clk_i, .rst_ni, .push_i (offs_push), .data_i (head.addr[1:0]), .full_o (),
    .pop_i (rsp_pop), .data_o (offs_head), .empty_o ()
  );

  // responses land here, r_valid cannot stall
  src_fifo #(.T (logic [MEM_W-1:0]), .DEPTH (OUT_DEPTH)) u_rsp_fifo (
    .clk_i, .rst_ni, .push_i (mem_rsp_i.r_valid), .data_i (mem_rsp_i.r_data),
    .full_o (), .pop_i (rsp_pop), .data_o (rsp_head), .empty_o (rsp_empty)
  );

  src_realign u_realign (
    .clk_i, .rst_ni, .rsp_valid_i (rsp_valid), .rsp_data_i (rsp_head),
    .offs_i (offs_head), .pop_o (rsp_pop),
    .stream_valid_o, .stream_data_o, .stream_ready_i
  );

endmodule

`default_nettype wire

// ==== verif/src_stream_properties.sv ====
// bound protocol checks on the source streamer top-level ports
`timescale 1ns/1ps
`default_nettype none

module src_stream_properties import src_stream_pkg::*; (
  input logic              clk_i,
  input logic              rst_ni,
  input mem_req_t          mem_req_o,
  input logic              mem_gnt_i,
  input logic              stream_valid_o,
  input logic [DATA_W-1:0] stream_data_o,
  input logic              stream_ready_i,
  input logic              busy_o,
  input logic              done_o
);

  // request and address held until granted
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o.req && !mem_gnt_i) |=> (mem_req_o.req && $stable(mem_req_o.addr)))
    else $error("memory request dropped or address changed before grant");

  a_stream_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (stream_valid_o && !stream_ready_i) |=> (stream_valid_o && $stable(stream_data_o)))
    else $error("stream beat changed or dropped under stall");

  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o)
    else $error("done held longer than one cycle");

  // no fetch outside a transfer
  a_req_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !busy_o |-> !mem_req_o.req)
    else $error("memory request while not busy");

endmodule

bind src_stream_top src_stream_properties u_props (
  .clk_i (clk_i), .rst_ni (rst_ni), .mem_req_o (mem_req_o), .mem_gnt_i (mem_gnt_i),
  .stream_valid_o (stream_valid_o), .stream_data_o (stream_data_o),
  .stream_ready_i (stream_ready_i), .busy_o (busy_o), .done_o (done_o)
);

`default_nettype wire

// ==== verif/src_stream_tb.sv ====
// testbench for the source streamer, apb driver, memory model and beat checker
`timescale 1ns/1ps
`default_nettype none

module src_stream_tb import src_stream_pkg::*; ();

  localparam int LIMIT = 20000; // all tests finish in a few thousand cycles

  logic clk_i;
  logic rst_ni;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  mem_req_t mem_req;
  logic mem_gnt;
  mem_rsp_t mem_rsp;
  logic stream_valid;
  logic [DATA_W-1:0] stream_data;
  logic stream_ready;
  logic busy;
  logic done;

  string test_name = "reset";
  bit rand_mode = 1'b0;         // random grant, latency, ready
  logic [31:0] rng = 32'd15;    // xorshift state
  int cycles = 0;
  int mem_cyc = 0;
  int last_due = 0;
  int lat;
  int due;
  int beat_cnt = 0;
  int done_cnt = 0;
  logic [31:0] q_addr[$];       // granted words, in order
  int q_due[$];                 // cycle each response is driven
  logic [31:0] pat_base;
  int pat_d0_len;
  logic [31:0] pat_d0_stride;
  logic [31:0] pat_d1_stride;

  src_stream_top #(.OUT_DEPTH (8), .ADDR_DEPTH (2)) u_src_stream_top (
    .clk_i, .rst_ni, .apb_req_i (apb_req), .apb_rsp_o (apb_rsp),
    .mem_req_o (mem_req), .mem_gnt_i (mem_gnt), .mem_rsp_i (mem_rsp),
    .stream_valid_o (stream_valid), .stream_data_o (stream_data),
    .stream_ready_i (stream_ready), .busy_o (busy), .done_o (done)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i; // 4 ns period

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [7:0] mem_byte(logic [31:0] a);
    return 8'(a * 7 + 3); // low byte of a*7+3
  endfunction

  function automatic logic [63:0] mem_word(logic [31:0] a);
    logic [63:0] w;
    for (int b = 0; b < 8; b++) w[8*b +: 8] = mem_byte(a + b);
    return w;
  endfunction

  // beat k: four bytes at the k-th pattern address, little endian
  function automatic logic [31:0] ref_beat(int k);
    logic [31:0] a;
    a = pat_base + (k / pat_d0_len) * pat_d1_stride + (k % pat_d0_len) * pat_d0_stride;
    return {mem_byte(a + 3), mem_byte(a + 2), mem_byte(a + 1), mem_byte(a)};
  endfunction

  task automatic fail_stop();
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond === 1'b1) else begin
      $display("%s: %s", test_name, msg);
      fail_stop();
    end
  endtask

  // setup cycle, access cycle, response sampled mid access
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk_i);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk_i);
    apb_req.penable <= 1'b1;
    @(negedge clk_i);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    check_true(apb_rsp.pready, "pready low in the apb access phase"); // no wait states
    @(posedge clk_i);
    apb_req <= '0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] rd;
    logic err;
    apb_xfer(1'b1, addr, data, rd, err);
    check_value("pslverr on write", 32'(exp_err), 32'(err));
  endtask

  task automatic reg_read_check(input logic [7:0] addr, input logic [31:0] exp, input logic exp_err);
    logic [31:0] rd;
    logic err;
    apb_xfer(1'b0, addr, 32'h0, rd, err);
    check_value("pslverr on read", 32'(exp_err), 32'(err));
    if (!exp_err) check_value("readback", exp, rd);
  endtask

  task automatic load_pattern(input logic [31:0] b, input int d0l, input logic [31:0] d0s,
                              input int d1l, input logic [31:0] d1s);
    pat_base      = b;
    pat_d0_len    = d0l;
    pat_d0_stride = d0s;
    pat_d1_stride = d1s;
    reg_write(REG_BASE, b, 1'b0);
    reg_write(REG_D0_LEN, 32'(d0l), 1'b0);
    reg_write(REG_D0_STRIDE, d0s, 1'b0);
    reg_write(REG_D1_LEN, 32'(d1l), 1'b0);
    reg_write(REG_D1_STRIDE, d1s, 1'b0);
  endtask

  // start, optionally poke start again while busy, then check counts at done
  task automatic run_pattern(input int n_beats, input bit try_restart);
    beat_cnt = 0;
    done_cnt = 0;
    reg_write(REG_CTRL, 32'h1, 1'b0);
    @(posedge clk_i);
    @(negedge clk_i);
    check_true(busy, "busy not raised two cycles after start");
    if (try_restart) reg_write(REG_CTRL, 32'h1, 1'b1); // refused while busy
    while (done_cnt == 0) @(negedge clk_i);
    repeat (3) @(negedge clk_i);
    check_value("beat count", 32'(n_beats), 32'(beat_cnt));
    check_value("done pulses", 32'd1, 32'(done_cnt));
    check_true(!busy, "busy still high after done");
  endtask

  // grant, ready and memory responses, one process so the rng order is fixed
  always @(posedge clk_i) begin
    mem_cyc = mem_cyc + 1;
    rng = xorshift32(rng);
    if (rand_mode) begin
      mem_gnt      <= rng[0] | rng[1];
      stream_ready <= |rng[3:2];
      lat = 1 + int'(rng[5:4]);
    end else begin
      mem_gnt      <= 1'b1;
      stream_ready <= 1'b1;
      lat = 1;
    end
    if (q_due.size() > 0 && q_due[0] == mem_cyc) begin
      mem_rsp <= '{r_valid: 1'b1, r_data: mem_word(q_addr[0])};
      void'(q_addr.pop_front());
      void'(q_due.pop_front());
    end else begin
      mem_rsp.r_valid <= 1'b0;
    end
    if (rst_ni && mem_req.req && mem_gnt) begin
      due = (mem_cyc + lat > last_due) ? mem_cyc + lat : last_due + 1; // in order
      last_due = due;
      q_addr.push_back(mem_req.addr);
      q_due.push_back(due);
    end
  end

  // compare each stream handshake with the reference
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (stream_valid && stream_ready) begin
        check_true(busy, "stream beat outside a transfer");
        check_value($sformatf("beat %0d", beat_cnt), ref_beat(beat_cnt), stream_data);
        beat_cnt = beat_cnt + 1;
      end
      if (done) done_cnt = done_cnt + 1;
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout after %0d cycles in %s, transfer never finished", LIMIT, test_name);
      fail_stop();
    end
  end

  initial begin
    rst_ni       = 1'b0;
    apb_req      = '0;
    mem_gnt      = 1'b0;
    mem_rsp      = '0;
    stream_ready = 1'b0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    test_name = "regs";
    load_pattern(32'h1234_5678, 16'h00AB, 32'h0000_0104, 16'h0033, 32'hFFFF_FFC0);
    reg_read_check(REG_BASE, 32'h1234_5678, 1'b0);
    reg_read_check(REG_D0_LEN, 32'h0000_00AB, 1'b0);
    reg_read_check(REG_D0_STRIDE, 32'h0000_0104, 1'b0);
    reg_read_check(REG_D1_LEN, 32'h0000_0033, 1'b0);
    reg_read_check(REG_D1_STRIDE, 32'hFFFF_FFC0, 1'b0);
    reg_read_check(REG_STATUS, 32'h0, 1'b0);
    reg_read_check(8'h40, 32'h0, 1'b1); // unmapped
    reg_write(8'h40, 32'h1, 1'b1);
    reg_write(REG_STATUS, 32'h3, 1'b1); // read only

    test_name = "aligned_1d";
    load_pattern(32'h0000_0200, 16, 32'h4, 1, 32'h0);
    run_pattern(16, 1'b0);

    test_name = "misaligned_2d";
    load_pattern(32'h0000_0103, 4, 32'h5, 3, 32'h40);
    run_pattern(12, 1'b0);

    test_name = "random_64";
    rand_mode = 1'b1;
    load_pattern(32'h0000_1001, 16, 32'h4, 4, 32'h101);
    run_pattern(64, 1'b0);

    test_name = "status";
    load_pattern(32'h0000_2002, 8, 32'hC, 8, 32'h80);
    run_pattern(64, 1'b1);
    reg_read_check(REG_STATUS, 32'h2, 1'b0); // done set, busy clear

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src_stream_top.f ====
rtl/src_stream_pkg.sv
rtl/src_fifo.sv
rtl/src_apb_regs.sv
rtl/src_addr_gen.sv
rtl/src_realign.sv
rtl/src_ctrl.sv
rtl/src_stream_top.sv
verif/src_stream_properties.sv
verif/src_stream_tb.sv
